// File: sources.f
rtl/bypass_pkg.sv
rtl/bypass_control.sv
rtl/stage_result_pipe.sv
rtl/reorder_buffer.sv
rtl/register_file.sv
rtl/operand_mux.sv
rtl/operand_fetch_top.sv
testbench/operand_fetch_assert.sv
testbench/operand_fetch_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = operand_fetch_tb
FILELIST = sources.f
OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the Verilator simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/operand_fetch_tb.sv
`timescale 1ns/1ps

module operand_fetch_tb;
	import bypass_pkg::*;

	localparam int n_checks = 3000;
	localparam int timeout_cycles = 50000;
	localparam int reset_cycles = 8;
	localparam int mid_reset_start = 1000;

	logic clk = 1'b0;
	logic reset;
	logic decode_valid;
	logic [reg_w-1:0] rs;
	logic [reg_w-1:0] rt;
	stage_result_t ex_result;
	logic rob_alloc;
	logic [reg_w-1:0] alloc_rd;
	logic rob_complete;
	rob_idx_t complete_index;
	logic [data_w-1:0] complete_value;
	logic operand_valid;
	operand_result_t rs_operand;
	operand_result_t rt_operand;
	rob_idx_t alloc_index;

	int seed = 47;
	int cycle = 0;
	int n_checked = 0;
	logic model_live = 1'b0;

	// Reference model of the architectural state and everything in flight
	logic [data_w-1:0] rf [32];
	stage_result_t stage [4];
	rob_entry_t rob [8];
	rob_idx_t head;
	rob_idx_t tail;
	int rob_count;
	logic exp_valid;
	operand_result_t exp_rs;
	operand_result_t exp_rt;

	operand_fetch_top #(.data_width(data_w)) operand_fetch_top_inst (
		.clk(clk),
		.reset(reset),
		.decode_valid(decode_valid),
		.rs(rs),
		.rt(rt),
		.ex_result(ex_result),
		.rob_alloc(rob_alloc),
		.alloc_rd(alloc_rd),
		.rob_complete(rob_complete),
		.complete_index(complete_index),
		.complete_value(complete_value),
		.operand_valid(operand_valid),
		.rs_operand(rs_operand),
		.rt_operand(rt_operand),
		.alloc_index(alloc_index)
	);

	always #10 clk = ~clk;

	task automatic report_mismatch(input string name, input logic [data_w-1:0] got,
			input logic [data_w-1:0] expected);
		$display("error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
		$display("CHECKS FAILED");
		$fatal(1, "mismatch on %s", name);
	endtask

	task automatic check_operand(input string name, input operand_result_t got,
			input operand_result_t expected);
		assert (got.pending == expected.pending)
			else report_mismatch({name, ".pending"}, data_w'(got.pending),
				data_w'(expected.pending));
		// A pending operand carries no meaningful value
		if (!expected.pending) begin
			assert (got.value == expected.value)
				else report_mismatch({name, ".value"}, got.value, expected.value);
		end
	endtask

	// A second reset in mid run clears operands that hold live values
	function automatic logic reset_at_cycle(input int c);
		return (c < reset_cycles)
			|| (c >= mid_reset_start && c < mid_reset_start + reset_cycles);
	endfunction

	// Mostly registers 0 to 7 so that producers collide often
	function automatic logic [reg_w-1:0] pick_reg();
		if (($random(seed) & 3) != 0) begin
			return reg_w'($random(seed) & 7);
		end
		return reg_w'($random(seed));
	endfunction

	// Oldest to newest over the buffer, then WB to EX, so the last writer is the youngest
	function automatic operand_result_t expected_operand(input logic [reg_w-1:0] r);
		operand_result_t res;
		rob_idx_t idx;
		res = '{value: rf[r], pending: 1'b0};
		for (int k = 0; k < rob_count; k++) begin
			idx = head + rob_idx_t'(k);
			if (rob[idx].rd == r) begin
				res = '{value: rob[idx].value, pending: !rob[idx].ready};
			end
		end
		for (int s = 3; s >= 0; s--) begin
			if (stage[s].valid && stage[s].rd == r) begin
				res = '{value: stage[s].value, pending: 1'b0};
			end
		end
		if (r == '0) begin
			res = '0;
		end
		return res;
	endfunction

	always @(posedge clk) begin
		logic commit;
		int pick;
		if (model_live) begin
			assert (operand_valid == exp_valid)
				else report_mismatch("operand_valid", data_w'(operand_valid), data_w'(exp_valid));
			assert (alloc_index == tail)
				else report_mismatch("alloc_index", data_w'(alloc_index), data_w'(tail));
			check_operand("rs_operand", rs_operand, exp_rs);
			check_operand("rt_operand", rt_operand, exp_rt);
			if (exp_valid) begin
				n_checked++;
			end
		end
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				rf[i] = '0;
			end
			for (int s = 0; s < 4; s++) begin
				stage[s].valid = 1'b0;
			end
			for (int i = 0; i < 8; i++) begin
				rob[i].valid = 1'b0;
				rob[i].ready = 1'b0;
			end
			head = '0;
			tail = '0;
			rob_count = 0;
			exp_valid = 1'b0;
			exp_rs = '0;
			exp_rt = '0;
			model_live = 1'b1;
		end else begin
			exp_valid = decode_valid;
			if (decode_valid) begin
				exp_rs = expected_operand(rs);
				exp_rt = expected_operand(rt);
			end
			// Commit goes in first so a WB write to the same register lands on top
			commit = rob[head].valid && rob[head].ready;
			if (commit) begin
				rf[rob[head].rd] = rob[head].value;
				rob[head].valid = 1'b0;
				rob[head].ready = 1'b0;
				head = head + rob_idx_t'(1);
				rob_count--;
			end
			if (stage[3].valid) begin
				rf[stage[3].rd] = stage[3].value;
			end
			if (rob_complete) begin
				rob[complete_index].ready = 1'b1;
				rob[complete_index].value = complete_value;
			end
			if (rob_alloc) begin
				rob[tail].valid = 1'b1;
				rob[tail].ready = 1'b0;
				rob[tail].rd = alloc_rd;
				tail = tail + rob_idx_t'(1);
				rob_count++;
			end
			for (int s = 3; s > 0; s--) begin
				stage[s] = stage[s-1];
			end
			stage[0] = ex_result;
		end
		cycle++;
		reset <= reset_at_cycle(cycle);
		pick = $random(seed) & 7;
		decode_valid <= (($random(seed) & 3) != 0);
		rs <= pick_reg();
		rt <= pick_reg();
		ex_result <= '{valid: (($random(seed) & 3) == 0), rd: pick_reg(),
			value: data_w'($random(seed))};
		rob_alloc <= (rob_count < 8) && (($random(seed) & 3) == 0);
		alloc_rd <= pick_reg();
		rob_complete <= rob[pick].valid && !rob[pick].ready && (($random(seed) & 1) != 0);
		complete_index <= rob_idx_t'(pick);
		complete_value <= data_w'($random(seed));
	end

	initial begin
		int waited;
		reset = 1'b1;
		decode_valid = 1'b0;
		rs = '0;
		rt = '0;
		ex_result = '0;
		rob_alloc = 1'b0;
		alloc_rd = '0;
		rob_complete = 1'b0;
		complete_index = '0;
		complete_value = '0;
		waited = 0;
		while (n_checked < n_checks && waited < timeout_cycles) begin
			@(posedge clk);
			waited++;
		end
		if (n_checked >= n_checks) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			$display("CHECKS FAILED");
			$fatal(1, "timed out after %0d cycles with %0d operand reads checked",
				waited, n_checked);
		end
	end

endmodule

// File: testbench/operand_fetch_assert.sv
`timescale 1ns/1ps

module operand_fetch_assert (
	input logic clk,
	input logic reset,
	input logic decode_valid,
	input logic [bypass_pkg::reg_w-1:0] rs,
	input logic [bypass_pkg::reg_w-1:0] rt,
	input logic operand_valid,
	input bypass_pkg::operand_result_t rs_operand,
	input bypass_pkg::operand_result_t rt_operand
);

	// operand_valid is the decode strobe delayed by exactly one cycle
	valid_follows_decode: assert property (@(posedge clk) disable iff (reset)
		decode_valid |=> operand_valid)
		else $error("operand_valid stayed low one cycle after decode_valid");

	no_spurious_valid: assert property (@(posedge clk) disable iff (reset)
		!decode_valid |=> !operand_valid)
		else $error("operand_valid rose without a decode_valid the cycle before");

	valid_low_after_reset: assert property (@(posedge clk)
		reset |=> !operand_valid)
		else $error("operand_valid was high right after a reset cycle");

	// Register 0 is hardwired, so it is never forwarded and never pending
	rs_zero_reads_zero: assert property (@(posedge clk) disable iff (reset)
		(decode_valid && rs == '0) |=> (rs_operand.value == '0 && !rs_operand.pending))
		else $error("a read of register 0 on rs gave a nonzero or pending operand");

	rt_zero_reads_zero: assert property (@(posedge clk) disable iff (reset)
		(decode_valid && rt == '0) |=> (rt_operand.value == '0 && !rt_operand.pending))
		else $error("a read of register 0 on rt gave a nonzero or pending operand");

endmodule

bind operand_fetch_top operand_fetch_assert operand_fetch_assert_inst (
	.clk(clk),
	.reset(reset),
	.decode_valid(decode_valid),
	.rs(rs),
	.rt(rt),
	.operand_valid(operand_valid),
	.rs_operand(rs_operand),
	.rt_operand(rt_operand)
);

// File: rtl/operand_fetch_top.sv
`timescale 1ns/1ps

module operand_fetch_top #(
	parameter int data_width = bypass_pkg::data_w
) (
	input logic clk,
	input logic reset,

	input logic decode_valid,
	input logic [bypass_pkg::reg_w-1:0] rs,
	input logic [bypass_pkg::reg_w-1:0] rt,

	input bypass_pkg::stage_result_t ex_result,

	input logic rob_alloc,
	input logic [bypass_pkg::reg_w-1:0] alloc_rd,
	input logic rob_complete,
	input bypass_pkg::rob_idx_t complete_index,
	input logic [data_width-1:0] complete_value,

	output logic operand_valid,
	output bypass_pkg::operand_result_t rs_operand,
	output bypass_pkg::operand_result_t rt_operand,
	output bypass_pkg::rob_idx_t alloc_index
);
	import bypass_pkg::*;

	stage_result_t ex_stage;
	stage_result_t tl_stage;
	stage_result_t c_stage;
	stage_result_t wb_stage;

	rob_entry_t [rob_depth-1:0] rob_entries;
	rob_idx_t rob_tail;
	logic commit_valid;
	logic [reg_w-1:0] commit_rd;
	logic [data_width-1:0] commit_value;
	logic [rob_depth-1:0][data_width-1:0] rob_values;

	logic [data_width-1:0] rf_rs_value;
	logic [data_width-1:0] rf_rt_value;

	operand_select_t rs_select;
	operand_select_t rt_select;

	stage_result_pipe #(.data_width(data_width)) stage_result_pipe_inst (
		.clk(clk),
		.reset(reset),
		.ex_result(ex_result),
		.ex_stage(ex_stage),
		.tl_stage(tl_stage),
		.c_stage(c_stage),
		.wb_stage(wb_stage)
	);

	reorder_buffer #(.data_width(data_width)) reorder_buffer_inst (
		.clk(clk),
		.reset(reset),
		.alloc(rob_alloc),
		.alloc_rd(alloc_rd),
		.complete(rob_complete),
		.complete_index(complete_index),
		.complete_value(complete_value),
		.entries(rob_entries),
		.tail(rob_tail),
		.alloc_index(alloc_index),
		.commit_valid(commit_valid),
		.commit_rd(commit_rd),
		.commit_value(commit_value)
	);

	// WB results take port 0, buffer commits take port 1
	register_file #(.data_width(data_width)) register_file_inst (
		.clk(clk),
		.reset(reset),
		.write0_valid(wb_stage.valid),
		.write0_rd(wb_stage.rd),
		.write0_value(wb_stage.value),
		.write1_valid(commit_valid),
		.write1_rd(commit_rd),
		.write1_value(commit_value),
		.read_a(rs),
		.read_b(rt),
		.data_a(rf_rs_value),
		.data_b(rf_rt_value)
	);

	bypass_control bypass_control_inst (
		.rs(rs),
		.rt(rt),
		.ex_stage(ex_stage),
		.tl_stage(tl_stage),
		.c_stage(c_stage),
		.wb_stage(wb_stage),
		.rob_entries(rob_entries),
		.rob_tail(rob_tail),
		.rs_select(rs_select),
		.rt_select(rt_select)
	);

	always_comb begin
		for (int i = 0; i < rob_depth; i++) begin
			rob_values[i] = rob_entries[i].value;
		end
	end

	operand_mux #(.data_width(data_width)) rs_mux_inst (
		.clk(clk),
		.reset(reset),
		.capture(decode_valid),
		.select(rs_select),
		.ex_value(ex_stage.value),
		.tl_value(tl_stage.value),
		.c_value(c_stage.value),
		.wb_value(wb_stage.value),
		.rob_values(rob_values),
		.rf_value(rf_rs_value),
		.operand(rs_operand)
	);

	operand_mux #(.data_width(data_width)) rt_mux_inst (
		.clk(clk),
		.reset(reset),
		.capture(decode_valid),
		.select(rt_select),
		.ex_value(ex_stage.value),
		.tl_value(tl_stage.value),
		.c_value(c_stage.value),
		.wb_value(wb_stage.value),
		.rob_values(rob_values),
		.rf_value(rf_rt_value),
		.operand(rt_operand)
	);

	// Operands land one cycle after the decode strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			operand_valid <= 1'b0;
		end else begin
			operand_valid <= decode_valid;
		end
	end

endmodule

// File: rtl/operand_mux.sv
`timescale 1ns/1ps

module operand_mux #(
	parameter int data_width = bypass_pkg::data_w
) (
	input logic clk,
	input logic reset,
	input logic capture,

	input bypass_pkg::operand_select_t select,

	input logic [data_width-1:0] ex_value,
	input logic [data_width-1:0] tl_value,
	input logic [data_width-1:0] c_value,
	input logic [data_width-1:0] wb_value,
	input logic [bypass_pkg::rob_depth-1:0][data_width-1:0] rob_values,
	input logic [data_width-1:0] rf_value,

	output bypass_pkg::operand_result_t operand
);
	import bypass_pkg::*;

	logic [data_width-1:0] value;

	always_comb begin
		case (select.source)
			src_ex: value = ex_value;
			src_tl: value = tl_value;
			src_c: value = c_value;
			src_wb: value = wb_value;
			src_rob: value = rob_values[select.rob_index];
			default: value = rf_value;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			operand <= '0;
		end else if (capture) begin
			operand.value <= value;
			operand.pending <= select.pending;
		end
	end

endmodule

// File: rtl/register_file.sv
`timescale 1ns/1ps

module register_file #(
	parameter int data_width = bypass_pkg::data_w
) (
	input logic clk,
	input logic reset,

	input logic write0_valid,
	input logic [bypass_pkg::reg_w-1:0] write0_rd,
	input logic [data_width-1:0] write0_value,

	input logic write1_valid,
	input logic [bypass_pkg::reg_w-1:0] write1_rd,
	input logic [data_width-1:0] write1_value,

	input logic [bypass_pkg::reg_w-1:0] read_a,
	input logic [bypass_pkg::reg_w-1:0] read_b,

	output logic [data_width-1:0] data_a,
	output logic [data_width-1:0] data_b
);
	import bypass_pkg::*;

	localparam int n_regs = 2 ** reg_w;

	logic [data_width-1:0] regs [n_regs];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < n_regs; i++) begin
				regs[i] <= '0;
			end
		end else begin
			// Port 0 is applied last so it wins when both ports hit one register
			if (write1_valid) begin
				regs[write1_rd] <= write1_value;
			end
			if (write0_valid) begin
				regs[write0_rd] <= write0_value;
			end
		end
	end

	// No write-through here, the WB forward already covers a same-cycle write
	assign data_a = (read_a == '0) ? '0 : regs[read_a];
	assign data_b = (read_b == '0) ? '0 : regs[read_b];

endmodule

// File: rtl/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer #(
	parameter int data_width = bypass_pkg::data_w
) (
	input logic clk,
	input logic reset,

	input logic alloc,
	input logic [bypass_pkg::reg_w-1:0] alloc_rd,

	input logic complete,
	input bypass_pkg::rob_idx_t complete_index,
	input logic [data_width-1:0] complete_value,

	output bypass_pkg::rob_entry_t [bypass_pkg::rob_depth-1:0] entries,
	output bypass_pkg::rob_idx_t tail,
	output bypass_pkg::rob_idx_t alloc_index,

	output logic commit_valid,
	output logic [bypass_pkg::reg_w-1:0] commit_rd,
	output logic [data_width-1:0] commit_value
);
	import bypass_pkg::*;

	logic [rob_depth-1:0] valid_q;
	logic [rob_depth-1:0] ready_q;
	logic [reg_w-1:0] rd_q [rob_depth];
	logic [data_width-1:0] value_q [rob_depth];
	rob_idx_t head;

	// The head retires as soon as its result is in
	assign commit_valid = valid_q[head] && ready_q[head];
	assign commit_rd = rd_q[head];
	assign commit_value = value_q[head];

	assign alloc_index = tail;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
			ready_q <= '0;
			head <= '0;
			tail <= '0;
		end else begin
			if (commit_valid) begin
				valid_q[head] <= 1'b0;
				ready_q[head] <= 1'b0;
				head <= head + 1'b1;
			end
			if (complete) begin
				ready_q[complete_index] <= 1'b1;
			end
			// The issuer never allocates into a full buffer, so the tail never meets a live head
			if (alloc) begin
				valid_q[tail] <= 1'b1;
				ready_q[tail] <= 1'b0;
				tail <= tail + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (alloc) begin
			rd_q[tail] <= alloc_rd;
		end
		if (complete) begin
			value_q[complete_index] <= complete_value;
		end
	end

	always_comb begin
		for (int i = 0; i < rob_depth; i++) begin
			entries[i] = '{
				valid: valid_q[i],
				ready: ready_q[i],
				rd: rd_q[i],
				value: value_q[i]
			};
		end
	end

endmodule

// File: rtl/stage_result_pipe.sv
`timescale 1ns/1ps

module stage_result_pipe #(
	parameter int data_width = bypass_pkg::data_w
) (
	input logic clk,
	input logic reset,

	input bypass_pkg::stage_result_t ex_result,

	output bypass_pkg::stage_result_t ex_stage,
	output bypass_pkg::stage_result_t tl_stage,
	output bypass_pkg::stage_result_t c_stage,
	output bypass_pkg::stage_result_t wb_stage
);
	import bypass_pkg::*;

	localparam int n_stages = 4;

	// Index 0 is EX and index 3 is WB
	logic [n_stages-1:0] valid_q;
	logic [reg_w-1:0] rd_q [n_stages];
	logic [data_width-1:0] value_q [n_stages];

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
		end else begin
			valid_q <= {valid_q[n_stages-2:0], ex_result.valid};
		end
	end

	always_ff @(posedge clk) begin
		rd_q[0] <= ex_result.rd;
		value_q[0] <= ex_result.value;
		for (int i = 1; i < n_stages; i++) begin
			rd_q[i] <= rd_q[i-1];
			value_q[i] <= value_q[i-1];
		end
	end

	assign ex_stage = '{valid: valid_q[0], rd: rd_q[0], value: value_q[0]};
	assign tl_stage = '{valid: valid_q[1], rd: rd_q[1], value: value_q[1]};
	assign c_stage = '{valid: valid_q[2], rd: rd_q[2], value: value_q[2]};
	assign wb_stage = '{valid: valid_q[3], rd: rd_q[3], value: value_q[3]};

endmodule

// File: rtl/bypass_control.sv
`timescale 1ns/1ps

module bypass_control (
	input logic [bypass_pkg::reg_w-1:0] rs,
	input logic [bypass_pkg::reg_w-1:0] rt,

	input bypass_pkg::stage_result_t ex_stage,
	input bypass_pkg::stage_result_t tl_stage,
	input bypass_pkg::stage_result_t c_stage,
	input bypass_pkg::stage_result_t wb_stage,

	input bypass_pkg::rob_entry_t [bypass_pkg::rob_depth-1:0] rob_entries,
	input bypass_pkg::rob_idx_t rob_tail,

	output bypass_pkg::operand_select_t rs_select,
	output bypass_pkg::operand_select_t rt_select
);
	import bypass_pkg::*;

	function automatic logic stage_hit(
		input stage_result_t stage,
		input logic [reg_w-1:0] r
	);
		return stage.valid && (stage.rd == r);
	endfunction

	// Youngest producer wins: the in-order stages first, then the reorder buffer
	// from the newest entry backwards, then the register file
	function automatic operand_select_t find_producer(input logic [reg_w-1:0] r);
		operand_select_t sel;
		rob_idx_t idx;
		logic rob_hit;

		sel.source = src_rf;
		sel.rob_index = '0;
		sel.pending = 1'b0;
		rob_hit = 1'b0;

		if (r == '0) begin
			sel.source = src_rf;
		end else if (stage_hit(ex_stage, r)) begin
			sel.source = src_ex;
		end else if (stage_hit(tl_stage, r)) begin
			sel.source = src_tl;
		end else if (stage_hit(c_stage, r)) begin
			sel.source = src_c;
		end else if (stage_hit(wb_stage, r)) begin
			sel.source = src_wb;
		end else begin
			// Walk from tail-1 down to tail-8, wrapping through index 0
			for (int k = 1; k <= rob_depth; k++) begin
				idx = rob_tail - rob_idx_t'(k);
				if (!rob_hit && rob_entries[idx].valid && rob_entries[idx].rd == r) begin
					rob_hit = 1'b1;
					sel.source = src_rob;
					sel.rob_index = idx;
					sel.pending = !rob_entries[idx].ready;
				end
			end
		end

		return sel;
	endfunction

	// Each operand runs its own search on its own register number
	always_comb begin
		rs_select = find_producer(rs);
		rt_select = find_producer(rt);
	end

endmodule

// File: rtl/bypass_pkg.sv
package bypass_pkg;

	// Register numbers select one of 32 architectural registers
	localparam int reg_w = 5;

	// Default register value width, the top level passes its own copy down
	localparam int data_w = 32;

	// The index wrap in the reorder buffer relies on this being a power of two
	localparam int rob_depth = 8;

	typedef logic [2:0] rob_idx_t;

	// One in-order result in one pipeline stage
	typedef struct packed {
		logic              valid;
		logic [reg_w-1:0]  rd;
		logic [data_w-1:0] value;
	} stage_result_t;

	typedef struct packed {
		logic              valid;
		logic              ready;
		logic [reg_w-1:0]  rd;
		logic [data_w-1:0] value;
	} rob_entry_t;

	typedef enum logic [2:0] {
		src_ex,
		src_tl,
		src_c,
		src_wb,
		src_rob,
		src_rf
	} operand_source_e;

	typedef struct packed {
		operand_source_e source;
		rob_idx_t        rob_index;
		logic            pending;
	} operand_select_t;

	typedef struct packed {
		logic [data_w-1:0] value;
		logic              pending;
	} operand_result_t;

endpackage
